// File: Bender.yml
package:
  name: zx_ula

sources:
  - design/zx_pkg.sv
  - design/screen.sv
  - design/cpucontrol.sv
  - design/ports.sv
  - design/memcontrol.sv
  - design/zx_ula.sv
  - target: simulation
    files:
      - tb/vram_model.sv
      - tb/tb_zx_ula.sv

// File: design/cpucontrol.sv
/* CPU clock and frame interrupt */

`timescale 1ns/1ps

module cpucontrol
    import zx_pkg::*;
(
    input  logic       clk28,
    input  logic       rst_n,
    input  cpu_bus_t   bus,
    input  logic [1:0] ck_phase,
    input  logic [8:0] hc,
    input  logic [8:0] vc,
    input  logic       contention,
    output logic       clkcpu,
    output logic       n_int
);

    logic       contended;
    logic       stall;
    logic       int_start;
    logic [8:0] int_cnt;

    // Accesses that compete with the screen for the ULA
    assign contended = (bus.mreq && bus.a[15:14] == VRAM_PAGE) ||
                       (bus.iorq && !bus.a[0]);

    // Only a high clock is frozen, so the CPU sees a long T-state
    assign stall = contention && contended && clkcpu;

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            clkcpu <= 1'b0;
        end else if (ck_phase == 2'd3 && !stall) begin
            clkcpu <= ~clkcpu;
        end
    end

    assign int_start = (vc == INT_LINE) && (hc == 9'd0) && (ck_phase == 2'd0);

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            n_int <= 1'b1;
            int_cnt <= 9'd0;
        end else if (int_start) begin
            n_int <= 1'b0;
            int_cnt <= INT_LEN - 9'd1;
        end else if (!n_int) begin
            if (int_cnt == 9'd0) begin
                n_int <= 1'b1;
            end else begin
                int_cnt <= int_cnt - 9'd1;
            end
        end
    end

endmodule

// File: design/memcontrol.sv
/* Video RAM arbiter */

`timescale 1ns/1ps

module memcontrol
    import zx_pkg::*;
(
    input  logic        clk28,
    input  logic        rst_n,
    input  cpu_bus_t    bus,
    input  fetch_req_t  fetch,
    input  logic [7:0]  port_dout,
    input  logic        port_dout_active,
    input  logic [7:0]  vram_rdata,
    output logic [7:0]  fetch_data,
    output logic [13:0] va,
    output logic [7:0]  vram_wdata,
    output logic        vram_we,
    output logic [7:0]  cpu_rdata,
    output logic        cpu_rdata_oe
);

    logic       cpu_vram;
    logic       done;
    logic       serve;
    logic       rd_pend;
    logic       mem_oe;
    logic [7:0] mem_latch;
    logic [7:0] mem_data;

    assign cpu_vram = bus.mreq && !bus.rfsh && (bus.a[15:14] == VRAM_PAGE) &&
                      (bus.rd || bus.wr);

    // Screen has priority, CPU takes any free cycle once per strobe
    assign serve = cpu_vram && !done && !fetch.valid;

    always_comb begin
        if (fetch.valid) begin
            va = {1'b0, fetch.addr} + (fetch.attr ? ATTR_BASE : 14'd0);
        end else begin
            va = bus.a[13:0];
        end
    end

    assign vram_we = serve && bus.wr;
    assign vram_wdata = bus.d;
    assign fetch_data = vram_rdata;

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            done <= 1'b0;
            rd_pend <= 1'b0;
            mem_oe <= 1'b0;
        end else begin
            if (!cpu_vram) begin
                done <= 1'b0;
            end else if (serve) begin
                done <= 1'b1;
            end
            rd_pend <= serve && bus.rd;
            if (!bus.rd) begin
                mem_oe <= 1'b0;
            end else if (rd_pend) begin
                mem_oe <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk28) begin
        if (rd_pend) begin
            mem_latch <= vram_rdata;
        end
    end

    // RAM output is passed straight through in the cycle it arrives
    assign mem_data = rd_pend ? vram_rdata : mem_latch;

    assign cpu_rdata = port_dout_active ? port_dout : mem_data;
    assign cpu_rdata_oe = port_dout_active || rd_pend || mem_oe;

endmodule

// File: design/ports.sv
/* Port 0xFE */

`timescale 1ns/1ps

module ports
    import zx_pkg::*;
(
    input  logic       clk28,
    input  logic       rst_n,
    input  cpu_bus_t   bus,
    input  logic [4:0] kd,
    input  logic       tape_in,
    output logic [7:0] port_dout,
    output logic       port_dout_active,
    output logic [2:0] border,
    output logic       snd,
    output logic       tape_out
);

    logic       io_sel;
    logic [4:0] kd_s1;
    logic [4:0] kd_s2;
    logic       tape_s1;
    logic       tape_s2;

    // Even port address, interrupt acknowledge excluded
    assign io_sel = bus.iorq && !bus.m1 && !bus.a[0];

    // Keyboard and tape are asynchronous to clk28
    always_ff @(posedge clk28) begin
        kd_s1 <= kd;
        kd_s2 <= kd_s1;
        tape_s1 <= tape_in;
        tape_s2 <= tape_s1;
    end

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            border <= 3'd0;
            tape_out <= 1'b0;
            snd <= 1'b0;
        end else if (io_sel && bus.wr) begin
            border <= bus.d[2:0];
            tape_out <= bus.d[3];
            snd <= bus.d[4];
        end
    end

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            port_dout_active <= 1'b0;
        end else begin
            port_dout_active <= io_sel && bus.rd;
        end
    end

    // Unused bits 7 and 5 read as one
    always_ff @(posedge clk28) begin
        port_dout <= {1'b1, tape_s2, 1'b1, kd_s2};
    end

endmodule

// File: design/screen.sv
/* Raster timing, fetch and video output */

`timescale 1ns/1ps

module screen
    import zx_pkg::*;
(
    input  logic       clk28,
    input  logic       rst_n,
    input  logic [2:0] border,
    input  logic [7:0] fetch_data,
    output fetch_req_t fetch,
    output logic [8:0] hc,
    output logic [8:0] vc,
    output logic [1:0] ck_phase,
    output logic       contention,
    output logic [1:0] r,
    output logic [1:0] g,
    output logic [1:0] b,
    output logic       hsync,
    output logic       vsync,
    output logic       csync
);

    logic        tick;
    logic        in_bitmap;
    logic        fetch_due;
    logic [12:0] bitmap_addr;
    logic [12:0] attr_addr;

    logic        fetch_q_valid;
    logic        fetch_q_attr;
    logic [7:0]  bitmap_buf;
    logic [7:0]  attr_buf;

    logic [7:0]  pix_sr;
    logic [7:0]  attr_q;

    logic [8:0]  hd;
    logic [8:0]  vd;
    logic        out_active;
    logic [7:0]  sr_next;
    logic [7:0]  attr_next;
    logic [2:0]  colour;
    logic        bright;
    logic        hs_on;
    logic        vs_on;

    assign tick = (ck_phase == 2'd3);

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            ck_phase <= 2'd0;
            hc <= 9'd0;
            vc <= 9'd0;
        end else begin
            ck_phase <= ck_phase + 2'd1;
            if (tick) begin
                if (hc == H_TOTAL - 9'd1) begin
                    hc <= 9'd0;
                    vc <= (vc == V_TOTAL - 9'd1) ? 9'd0 : vc + 9'd1;
                end else begin
                    hc <= hc + 9'd1;
                end
            end
        end
    end

    assign in_bitmap = (hc < H_ACTIVE) && (vc < V_ACTIVE);
    assign contention = in_bitmap && !hc[2];

    // Bitmap in pixel clock 0, attribute in pixel clock 1 of each group
    assign fetch_due = in_bitmap && (ck_phase == 2'd0) && (hc[2:1] == 2'b00);
    assign bitmap_addr = {vc[7:6], vc[2:0], vc[5:3], hc[7:3]};
    assign attr_addr = {3'b000, vc[7:3], hc[7:3]};

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            fetch <= '0;
            fetch_q_valid <= 1'b0;
            fetch_q_attr <= 1'b0;
        end else begin
            fetch.valid <= fetch_due;
            fetch.attr <= hc[0];
            fetch.addr <= hc[0] ? attr_addr : bitmap_addr;
            fetch_q_valid <= fetch.valid;
            fetch_q_attr <= fetch.attr;
        end
    end

    // RAM answers one cycle after the request
    always_ff @(posedge clk28) begin
        if (fetch_q_valid) begin
            if (fetch_q_attr) begin
                attr_buf <= fetch_data;
            end else begin
                bitmap_buf <= fetch_data;
            end
        end
    end

    // Position of the pixel shown after the next tick
    always_comb begin
        if (hc >= OUT_DELAY - 9'd1) begin
            hd = hc - (OUT_DELAY - 9'd1);
            vd = vc;
        end else begin
            hd = hc + H_TOTAL - (OUT_DELAY - 9'd1);
            vd = (vc == 9'd0) ? V_TOTAL - 9'd1 : vc - 9'd1;
        end
    end

    assign out_active = (hd < H_ACTIVE) && (vd < V_ACTIVE);
    assign sr_next = (hd[2:0] == 3'd0) ? bitmap_buf : {pix_sr[6:0], 1'b0};
    assign attr_next = (hd[2:0] == 3'd0) ? attr_buf : attr_q;

    always_comb begin
        if (out_active) begin
            colour = sr_next[7] ? attr_next[2:0] : attr_next[5:3];
            bright = attr_next[6];
        end else begin
            colour = border;
            bright = 1'b0;
        end
    end

    assign hs_on = (hd >= H_SYNC_START) && (hd < H_SYNC_START + H_SYNC_LEN);
    assign vs_on = (vd >= V_SYNC_START) && (vd < V_SYNC_START + V_SYNC_LEN);

    always_ff @(posedge clk28) begin
        if (tick) begin
            pix_sr <= sr_next;
            attr_q <= attr_next;
        end
    end

    // Colour bits are G R B from high to low
    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            r <= 2'b00;
            g <= 2'b00;
            b <= 2'b00;
            hsync <= 1'b1;
            vsync <= 1'b1;
            csync <= 1'b1;
        end else if (tick) begin
            r <= {colour[1], colour[1] & bright};
            g <= {colour[2], colour[2] & bright};
            b <= {colour[0], colour[0] & bright};
            hsync <= ~hs_on;
            vsync <= ~vs_on;
            csync <= ~(hs_on ^ vs_on);
        end
    end

endmodule

// File: design/zx_pkg.sv
/* ULA shared timing and bus types */

package zx_pkg;

    // Raster in 7 MHz pixel clocks and lines
    localparam logic [8:0] H_TOTAL = 9'd448;
    localparam logic [8:0] V_TOTAL = 9'd312;
    localparam logic [8:0] H_ACTIVE = 9'd256;
    localparam logic [8:0] V_ACTIVE = 9'd192;

    localparam logic [8:0] H_SYNC_START = 9'd336;
    localparam logic [8:0] H_SYNC_LEN = 9'd32;
    localparam logic [8:0] V_SYNC_START = 9'd248;
    localparam logic [8:0] V_SYNC_LEN = 9'd4;

    // Frame interrupt, length in clk28 cycles
    localparam logic [8:0] INT_LINE = 9'd248;
    localparam logic [8:0] INT_LEN = 9'd256;

    // Fetch to screen output latency in pixel clocks
    localparam logic [8:0] OUT_DELAY = 9'd8;

    // Attribute area follows the 6144-byte bitmap
    localparam logic [13:0] ATTR_BASE = 14'd6144;

    // a[15:14] of the 0x4000-0x7FFF window
    localparam logic [1:0] VRAM_PAGE = 2'b01;

    // Z80 bus, strobes already active high
    typedef struct packed {
        logic [15:0] a;
        logic [7:0]  d;
        logic        mreq;
        logic        iorq;
        logic        rd;
        logic        wr;
        logic        m1;
        logic        rfsh;
    } cpu_bus_t;

    // One screen byte request, addr is the offset within the screen
    typedef struct packed {
        logic        valid;
        logic        attr;
        logic [12:0] addr;
    } fetch_req_t;

endpackage

// File: design/zx_ula.sv
/* ZX Spectrum 48K ULA */

`timescale 1ns/1ps

module zx_ula
    import zx_pkg::*;
(
    input  logic        clk28,
    input  logic        rst_n,

    input  logic [15:0] xa,
    input  logic [7:0]  xd,
    input  logic        n_rd,
    input  logic        n_wr,
    input  logic        n_mreq,
    input  logic        n_iorq,
    input  logic        n_m1,
    input  logic        n_rfsh,
    output logic [7:0]  cpu_rdata,
    output logic        cpu_rdata_oe,
    output logic        clkcpu,
    output logic        n_int,

    input  logic [4:0]  kd,
    input  logic        tape_in,

    output logic [13:0] va,
    output logic [7:0]  vram_wdata,
    output logic        vram_we,
    input  logic [7:0]  vram_rdata,

    output logic [1:0]  r,
    output logic [1:0]  g,
    output logic [1:0]  b,
    output logic        hsync,
    output logic        vsync,
    output logic        csync,

    output logic        snd,
    output logic        tape_out
);

    cpu_bus_t   bus;
    fetch_req_t fetch;
    logic [7:0] fetch_data;
    logic [2:0] border;
    logic [8:0] hc;
    logic [8:0] vc;
    logic [1:0] ck_phase;
    logic       contention;
    logic [7:0] port_dout;
    logic       port_dout_active;

    // Active high view of the Z80 pins
    assign bus = '{
        a:    xa,
        d:    xd,
        mreq: ~n_mreq,
        iorq: ~n_iorq,
        rd:   ~n_rd,
        wr:   ~n_wr,
        m1:   ~n_m1,
        rfsh: ~n_rfsh
    };

    screen screen0 (
        .clk28      (clk28),
        .rst_n      (rst_n),
        .border     (border),
        .fetch_data (fetch_data),
        .fetch      (fetch),
        .hc         (hc),
        .vc         (vc),
        .ck_phase   (ck_phase),
        .contention (contention),
        .r          (r),
        .g          (g),
        .b          (b),
        .hsync      (hsync),
        .vsync      (vsync),
        .csync      (csync)
    );

    cpucontrol cpucontrol0 (
        .clk28      (clk28),
        .rst_n      (rst_n),
        .bus        (bus),
        .ck_phase   (ck_phase),
        .hc         (hc),
        .vc         (vc),
        .contention (contention),
        .clkcpu     (clkcpu),
        .n_int      (n_int)
    );

    ports ports0 (
        .clk28            (clk28),
        .rst_n            (rst_n),
        .bus              (bus),
        .kd               (kd),
        .tape_in          (tape_in),
        .port_dout        (port_dout),
        .port_dout_active (port_dout_active),
        .border           (border),
        .snd              (snd),
        .tape_out         (tape_out)
    );

    memcontrol memcontrol0 (
        .clk28            (clk28),
        .rst_n            (rst_n),
        .bus              (bus),
        .fetch            (fetch),
        .port_dout        (port_dout),
        .port_dout_active (port_dout_active),
        .vram_rdata       (vram_rdata),
        .fetch_data       (fetch_data),
        .va               (va),
        .vram_wdata       (vram_wdata),
        .vram_we          (vram_we),
        .cpu_rdata        (cpu_rdata),
        .cpu_rdata_oe     (cpu_rdata_oe)
    );

endmodule

// File: files.f
design/zx_pkg.sv
design/screen.sv
design/cpucontrol.sv
design/ports.sv
design/memcontrol.sv
design/zx_ula.sv
tb/vram_model.sv
tb/tb_zx_ula.sv

// File: tb/tb_zx_ula.sv
/* ULA testbench */

`timescale 1ns/1ps

module tb_zx_ula
    import zx_pkg::*;
();

    logic        clk28 = 1'b0;
    logic        rst_n;
    logic [15:0] xa;
    logic [7:0]  xd;
    logic        n_rd;
    logic        n_wr;
    logic        n_mreq;
    logic        n_iorq;
    logic        n_m1;
    logic        n_rfsh;
    logic [4:0]  kd;
    logic        tape_in;
    logic [7:0]  cpu_rdata;
    logic        cpu_rdata_oe;
    logic        clkcpu;
    logic        n_int;
    logic [13:0] va;
    logic [7:0]  vram_wdata;
    logic        vram_we;
    logic [7:0]  vram_rdata;
    logic [1:0]  r;
    logic [1:0]  g;
    logic [1:0]  b;
    logic        hsync;
    logic        vsync;
    logic        csync;
    logic        snd;
    logic        tape_out;

    int frame_pix = int'(H_TOTAL) * int'(V_TOTAL);
    int frame_cyc = 4 * int'(H_TOTAL) * int'(V_TOTAL);
    int int_pos = 4 * int'(H_TOTAL) * int'(INT_LINE);

    int          cyc;
    int          video_errs = 0;
    int          irq_errs = 0;
    int          bus_errs = 0;
    int          active_checks = 0;
    int          border_checks = 0;
    int          irq_falls = 0;
    int          low_cnt = 0;
    int          last_fall = 0;
    logic        prev_int = 1'b1;
    logic        border_known = 1'b1;
    logic [2:0]  border_exp = 3'd0;
    logic        read_busy = 1'b0;

    zx_ula i_dut (.*);

    vram_model vram (
        .clk28 (clk28),
        .addr  (va),
        .wdata (vram_wdata),
        .we    (vram_we),
        .rdata (vram_rdata)
    );

    always #2 clk28 = ~clk28;

    // clk28 edges since reset release
    always @(posedge clk28) begin
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic show_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    endtask

    function automatic logic [7:0] attr_pattern(input int j);
        return 8'((j * 13 + 7) & 8'h7f);
    endfunction

    // Expected r, g, b pairs for a GRB colour and bright
    function automatic logic [5:0] colour_rgb(input logic [2:0] c, input logic br);
        return {c[1], c[1] & br, c[2], c[2] & br, c[0], c[0] & br};
    endfunction

    function automatic logic [5:0] screen_rgb(input int x, input int y);
        logic [7:0]  yy;
        logic [7:0]  xx;
        logic [12:0] offs;
        logic [7:0]  attr;
        logic [2:0]  c;
        yy = 8'(y);
        xx = 8'(x);
        offs = {yy[7:6], yy[2:0], yy[5:3], xx[7:3]};
        attr = attr_pattern((y / 8) * 32 + x / 8);
        c = offs[7 - (x % 8)] ? attr[2:0] : attr[5:3];
        return colour_rgb(c, attr[6]);
    endfunction

    // Video output shows the pixel 8 pixel clocks behind the raster
    always @(negedge clk28) begin
        int p;
        int x;
        int y;
        logic hs;
        logic vs;
        logic [5:0] exp_rgb;
        if (rst_n === 1'b1 && cyc >= 32) begin
            p = (cyc / 4 - 8) % frame_pix;
            x = p % int'(H_TOTAL);
            y = p / int'(H_TOTAL);
            hs = (x >= int'(H_SYNC_START)) && (x < int'(H_SYNC_START + H_SYNC_LEN));
            vs = (y >= int'(V_SYNC_START)) && (y < int'(V_SYNC_START + V_SYNC_LEN));
            assert (hsync === !hs) else begin
                video_errs++;
                show_mismatch("hsync", 16'(!hs), 16'(hsync));
            end
            assert (vsync === !vs) else begin
                video_errs++;
                show_mismatch("vsync", 16'(!vs), 16'(vsync));
            end
            assert (csync === !(hs ^ vs)) else begin
                video_errs++;
                show_mismatch("csync", 16'(!(hs ^ vs)), 16'(csync));
            end
            if (x < int'(H_ACTIVE) && y < int'(V_ACTIVE)) begin
                exp_rgb = screen_rgb(x, y);
                active_checks++;
                assert ({r, g, b} === exp_rgb) else begin
                    video_errs++;
                    show_mismatch("rgb", 16'(exp_rgb), 16'({r, g, b}));
                end
            end else if (border_known) begin
                exp_rgb = colour_rgb(border_exp, 1'b0);
                border_checks++;
                assert ({r, g, b} === exp_rgb) else begin
                    video_errs++;
                    show_mismatch("rgb", 16'(exp_rgb), 16'({r, g, b}));
                end
            end
        end
    end

    // Interrupt width, position and period
    always @(negedge clk28) begin
        if (rst_n === 1'b1) begin
            if (!n_int) begin
                low_cnt++;
            end
            if (prev_int && !n_int) begin
                irq_falls++;
                assert ((cyc - 1) % frame_cyc == int_pos) else begin
                    irq_errs++;
                    show_mismatch("n_int fall", 16'(int_pos), 16'((cyc - 1) % frame_cyc));
                end
                if (irq_falls > 1) begin
                    assert (cyc - last_fall == frame_cyc) else begin
                        irq_errs++;
                        $display("ERR %0t n_int period expected %0d actual %0d",
                                 $time, frame_cyc, cyc - last_fall);
                    end
                end
                last_fall = cyc;
            end
            if (!prev_int && n_int) begin
                assert (low_cnt == int'(INT_LEN)) else begin
                    irq_errs++;
                    show_mismatch("n_int width", 16'(INT_LEN), 16'(low_cnt));
                end
                low_cnt = 0;
            end
            prev_int = n_int;
            if (!read_busy) begin
                assert (cpu_rdata_oe === 1'b0) else begin
                    bus_errs++;
                    show_mismatch("cpu_rdata_oe", 16'd0, 16'(cpu_rdata_oe));
                end
            end
        end
    end

    task automatic wait_oe(input logic level, input string what);
        bit ok;
        ok = 0;
        for (int i = 0; i < 64 && !ok; i++) begin
            @(negedge clk28);
            ok = (cpu_rdata_oe === level);
        end
        if (!ok) begin
            bus_errs++;
            $display("Timeout waiting for %s", what);
        end
    endtask

    // Start of an 8-pixel group inside the bitmap area
    task automatic wait_contention();
        bit ok;
        int hp;
        int vp;
        ok = 0;
        for (int i = 0; i < 600000 && !ok; i++) begin
            @(negedge clk28);
            hp = (cyc / 4) % int'(H_TOTAL);
            vp = (cyc / 4 / int'(H_TOTAL)) % int'(V_TOTAL);
            ok = (cyc % 4 == 0) && (hp % 8 == 0) && hp < int'(H_ACTIVE) &&
                 vp < int'(V_ACTIVE);
        end
        if (!ok) begin
            bus_errs++;
            $display("Timeout waiting for a contention window");
        end
    endtask

    task automatic check_clkcpu_runs();
        bit ok;
        logic c0;
        ok = 0;
        @(negedge clk28);
        c0 = clkcpu;
        for (int i = 0; i < 64 && !ok; i++) begin
            @(negedge clk28);
            ok = (clkcpu !== c0);
        end
        if (!ok) begin
            bus_errs++;
            $display("clkcpu did not resume toggling after the access");
        end
    endtask

    task automatic port_write(input logic [7:0] data);
        logic [15:0] addr;
        addr = 16'($urandom) & 16'hfffe;
        border_known = 1'b0;
        @(posedge clk28);
        xa <= addr;
        xd <= data;
        n_iorq <= 1'b0;
        n_wr <= 1'b0;
        repeat (2) @(posedge clk28);
        n_iorq <= 1'b1;
        n_wr <= 1'b1;
        repeat (12) @(negedge clk28);
        assert (snd === data[4]) else begin
            bus_errs++;
            show_mismatch("snd", 16'(data[4]), 16'(snd));
        end
        assert (tape_out === data[3]) else begin
            bus_errs++;
            show_mismatch("tape_out", 16'(data[3]), 16'(tape_out));
        end
        border_exp = data[2:0];
        border_known = 1'b1;
    endtask

    task automatic port_read();
        logic [15:0] addr;
        logic [4:0]  kv;
        logic        tv;
        logic [7:0]  exp;
        addr = 16'($urandom) & 16'hfffe;
        kv = 5'($urandom);
        tv = 1'($urandom);
        exp = {1'b1, tv, 1'b1, kv};
        @(posedge clk28);
        kd <= kv;
        tape_in <= tv;
        repeat (4) @(posedge clk28);
        read_busy = 1'b1;
        xa <= addr;
        n_iorq <= 1'b0;
        n_rd <= 1'b0;
        wait_oe(1'b1, "port read data");
        assert (cpu_rdata === exp) else begin
            bus_errs++;
            show_mismatch("cpu_rdata", 16'(exp), 16'(cpu_rdata));
        end
        @(posedge clk28);
        n_iorq <= 1'b1;
        n_rd <= 1'b1;
        wait_oe(1'b0, "end of port read");
        read_busy = 1'b0;
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        bit ok;
        ok = 0;
        @(posedge clk28);
        xa <= addr;
        xd <= data;
        n_mreq <= 1'b0;
        n_wr <= 1'b0;
        for (int i = 0; i < 64 && !ok; i++) begin
            @(negedge clk28);
            ok = (vram_we === 1'b1);
        end
        if (!ok) begin
            bus_errs++;
            $display("Timeout waiting for the video RAM write");
        end else begin
            assert (va === addr[13:0]) else begin
                bus_errs++;
                show_mismatch("va", 16'(addr[13:0]), 16'(va));
            end
            assert (vram_wdata === data) else begin
                bus_errs++;
                show_mismatch("vram_wdata", 16'(data), 16'(vram_wdata));
            end
        end
        @(posedge clk28);
        n_mreq <= 1'b1;
        n_wr <= 1'b1;
    endtask

    task automatic mem_read(input logic [15:0] addr, input logic [7:0] exp);
        @(posedge clk28);
        read_busy = 1'b1;
        xa <= addr;
        n_mreq <= 1'b0;
        n_rd <= 1'b0;
        wait_oe(1'b1, "memory read data");
        assert (cpu_rdata === exp) else begin
            bus_errs++;
            show_mismatch("cpu_rdata", 16'(exp), 16'(cpu_rdata));
        end
        @(posedge clk28);
        n_mreq <= 1'b1;
        n_rd <= 1'b1;
        wait_oe(1'b0, "end of memory read");
        read_busy = 1'b0;
    endtask

    initial begin
        logic [15:0] addr;
        logic [7:0]  data;
        bit          ok;
        void'($urandom(32'h1a87_383a));
        rst_n = 1'b0;
        xa = 16'h0000;
        xd = 8'h00;
        n_rd = 1'b1;
        n_wr = 1'b1;
        n_mreq = 1'b1;
        n_iorq = 1'b1;
        n_m1 = 1'b1;
        n_rfsh = 1'b1;
        kd = 5'h1f;
        tape_in = 1'b0;
        repeat (3) @(posedge clk28);
        rst_n <= 1'b1;

        for (int i = 0; i < 3; i++) begin
            port_write(8'($urandom));
            // Let a full line of border pass
            repeat (1800) @(posedge clk28);
        end
        for (int i = 0; i < 3; i++) begin
            port_read();
        end

        // Addresses above the screen area so the picture stays intact
        for (int i = 0; i < 6; i++) begin
            addr = 16'h5b00 + 16'($urandom % 32'h2500);
            data = 8'($urandom);
            if (i % 2 == 0) begin
                wait_contention();
            end
            mem_write(addr, data);
            check_clkcpu_runs();
            if (i % 2 == 0) begin
                wait_contention();
            end
            mem_read(addr, data);
            check_clkcpu_runs();
        end

        ok = 0;
        for (int i = 0; i < 1300000 && !ok; i++) begin
            @(negedge clk28);
            ok = (irq_falls >= 2) && n_int;
        end
        if (!ok) begin
            irq_errs++;
            $display("Timeout waiting for two frame interrupts");
        end
        if (active_checks == 0 || border_checks == 0) begin
            video_errs++;
            $display("No active or border pixels were checked");
        end

        $display("Errors: video %0d, interrupt %0d, bus %0d",
                 video_errs, irq_errs, bus_errs);
        if (video_errs == 0 && irq_errs == 0 && bus_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb/vram_model.sv
/* Video RAM model */

`timescale 1ns/1ps

module vram_model (
    input  logic        clk28,
    input  logic [13:0] addr,
    input  logic [7:0]  wdata,
    input  logic        we,
    output logic [7:0]  rdata
);

    logic [7:0] mem [0:16383];

    // Attribute pattern, bit 7 kept clear
    function automatic logic [7:0] attr_pattern(input int j);
        return 8'((j * 13 + 7) & 8'h7f);
    endfunction

    function automatic logic [7:0] fill_byte(input int a);
        logic [13:0] aa;
        aa = 14'(a);
        if (a < 6144) begin
            return aa[7:0];
        end else if (a < 6912) begin
            return attr_pattern(a - 6144);
        end else begin
            return aa[7:0] ^ {2'b00, aa[13:8]};
        end
    endfunction

    initial begin
        for (int a = 0; a < 16384; a++) begin
            mem[a] = fill_byte(a);
        end
    end

    // One cycle read latency, old data on a write
    always @(posedge clk28) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule
